/* all.f */
+incdir+include
logic/rename_pkg.sv
logic/pipe_stage.sv
logic/free_list.sv
logic/rename_table.sv
logic/retire_table.sv
logic/rename_unit.sv
tests/rename_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds the rename unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rename_unit_tb \
    --Mdir build \
    -o rename_unit_sim \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/rename_unit_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0

/* tests/rename_unit_tb.sv */
`default_nettype none

`include "rename_defs.svh"

module rename_unit_tb;

    localparam logic [31:0] SEED = 32'h569e_9db8;
    localparam int TIMEOUT_CYCLES = 200;

    typedef enum logic [2:0] {OP_RENAME, OP_RANDOM, OP_RETIRE, OP_SQUASH, OP_BLOCKED} op_t;

    typedef struct packed {
        op_t                         op;
        rename_pkg::rename_request_t request;
        rename_pkg::rename_result_t  expected;
        logic [7:0]                  count;
    } step_t;

    typedef struct packed {
        logic                        has_expected;
        rename_pkg::rename_request_t request;
        rename_pkg::rename_result_t  expected;
    } pending_t;

    logic                        clock;
    logic                        reset;
    logic                        squash;
    logic                        request_valid;
    logic                        request_ready;
    rename_pkg::rename_request_t request;
    logic                        result_valid;
    logic                        result_ready;
    rename_pkg::rename_result_t  result;
    rename_pkg::retire_bundle_t  retire;

    // Reference model of both maps and the order in which registers become free
    rename_pkg::prn_t          spec_map [`ARCH_REG_COUNT];
    rename_pkg::prn_t          commit_map [`ARCH_REG_COUNT];
    rename_pkg::prn_t          free_order [$];
    int                        spec_head;
    int                        commit_head;
    rename_pkg::retire_slot_t  allocations [$];

    pending_t    pending [$];
    step_t       steps [$];
    logic [31:0] stall_state;
    logic [31:0] arn_state;

    rename_unit rename_unit_i (
        .clock         (clock),
        .reset         (reset),
        .squash        (squash),
        .request_valid (request_valid),
        .request_ready (request_ready),
        .request       (request),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result        (result),
        .retire        (retire)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic rename_pkg::rename_request_t make_request(input int a0, b0, d0,
                                                                 input int a1, b1, d1);
        rename_pkg::rename_request_t r;
        r[0] = {rename_pkg::arn_t'(a0), rename_pkg::arn_t'(b0), rename_pkg::arn_t'(d0)};
        r[1] = {rename_pkg::arn_t'(a1), rename_pkg::arn_t'(b1), rename_pkg::arn_t'(d1)};
        return r;
    endfunction

    function automatic rename_pkg::rename_result_t make_result(input int a0, b0, d0,
                                                               input int a1, b1, d1);
        rename_pkg::rename_result_t r;
        r[0] = {rename_pkg::prn_t'(a0), rename_pkg::prn_t'(b0), rename_pkg::prn_t'(d0)};
        r[1] = {rename_pkg::prn_t'(a1), rename_pkg::prn_t'(b1), rename_pkg::prn_t'(d1)};
        return r;
    endfunction

    // Random traffic stays in registers 16 to 31, so directed bundles keep their mappings
    function automatic rename_pkg::rename_request_t random_request();
        rename_pkg::rename_request_t r;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            arn_state = xorshift32(arn_state);
            r[i].op1_arn  = {1'b1, arn_state[3:0]};
            r[i].op2_arn  = {1'b1, arn_state[11:8]};
            r[i].dest_arn = {1'b1, arn_state[19:16]};
        end
        return r;
    endfunction

    task automatic add_rename(input rename_pkg::rename_request_t bundle,
                              input rename_pkg::rename_result_t expected);
        steps.push_back('{OP_RENAME, bundle, expected, 8'd0});
    endtask

    task automatic add_step(input op_t op, input int count);
        steps.push_back('{op, '0, '0, 8'(count)});
    endtask

    // Sources read the map as updated by earlier slots, destinations take the next free entry
    task automatic predict_rename(input rename_pkg::rename_request_t bundle,
                                  output rename_pkg::rename_result_t predicted);
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            predicted[i].op1_prn  = spec_map[bundle[i].op1_arn];
            predicted[i].op2_prn  = spec_map[bundle[i].op2_arn];
            predicted[i].dest_prn = '0;
            if (bundle[i].dest_arn != `ZERO_REG) begin
                if (spec_head >= free_order.size()) begin
                    $display("The reference model has no free register for a result");
                    stop_with_failure();
                end
                predicted[i].dest_prn = free_order[spec_head];
                spec_head++;
                spec_map[bundle[i].dest_arn] = predicted[i].dest_prn;
                allocations.push_back({1'b1, bundle[i].dest_arn, predicted[i].dest_prn});
            end
        end
    endtask

    task automatic take_result();
        pending_t                   entry;
        rename_pkg::rename_result_t predicted;
        if (pending.size() == 0) begin
            $display("A result came out at time %0t with no request in flight", $time);
            stop_with_failure();
        end else begin
            entry = pending.pop_front();
            predict_rename(entry.request, predicted);
            check_value(result, predicted, "result against the reference model");
            if (entry.has_expected) begin
                check_value(result, entry.expected, "result against the stimulus table");
            end
        end
    endtask

    task automatic wait_pending(input int target, input string what);
        int cycles;
        cycles = 0;
        while (pending.size() > target) begin
            @(posedge clock);
            #5;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for %s", cycles, what);
                stop_with_failure();
            end
        end
    endtask

    task automatic apply_rename(input rename_pkg::rename_request_t bundle,
                                input rename_pkg::rename_result_t expected,
                                input logic has_expected);
        int cycles;
        cycles = 0;
        request       = bundle;
        request_valid = 1'b1;
        @(posedge clock);
        while (!request_ready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out after %0d cycles waiting for request_ready", cycles);
                stop_with_failure();
            end
            @(posedge clock);
        end
        pending.push_back({has_expected, bundle, expected});
        #5;
        request_valid = 1'b0;
        request       = '0;
    endtask

    // Retires the oldest renamed destinations in program order
    task automatic apply_retire(input int count);
        rename_pkg::retire_bundle_t bundle;
        rename_pkg::retire_slot_t   slot;
        int                         cycles;
        cycles = 0;
        while (allocations.size() < count) begin
            @(posedge clock);
            #5;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timed out waiting for renamed destinations to retire");
                stop_with_failure();
            end
        end
        bundle = '0;
        for (int i = 0; i < count; i++) begin
            slot      = allocations.pop_front();
            bundle[i] = slot;
            // The register this slot replaces goes to the back of the free list
            free_order.push_back(commit_map[slot.dest_arn]);
            commit_map[slot.dest_arn] = slot.dest_prn;
            commit_head++;
        end
        retire = bundle;
        @(posedge clock);
        #5;
        retire = '0;
    endtask

    task automatic apply_squash();
        wait_pending(0, "the results ahead of a squash");
        squash = 1'b1;
        @(posedge clock);
        check_value(request_ready, 1'b0, "request_ready during squash");
        #5;
        squash      = 1'b0;
        spec_map    = commit_map;
        spec_head   = commit_head;
        allocations.delete();
    endtask

    task automatic check_blocked(input int count);
        wait_pending(1, "the bundles ahead of the blocked one");
        for (int n = 0; n < count; n++) begin
            @(posedge clock);
            check_value(request_ready, 1'b0, "request_ready with no free register");
            #5;
            check_value(pending.size(), 1, "bundles in flight while blocked");
        end
    endtask

    task automatic run_step(input step_t step);
        case (step.op)
            OP_RENAME:  apply_rename(step.request, step.expected, 1'b1);
            OP_RANDOM: begin
                for (int n = 0; n < step.count; n++) begin
                    apply_rename(random_request(), '0, 1'b0);
                end
            end
            OP_RETIRE:  apply_retire(step.count);
            OP_SQUASH:  apply_squash();
            OP_BLOCKED: check_blocked(step.count);
            default: begin
                $display("The stimulus table holds an unknown operation");
                stop_with_failure();
            end
        endcase
    endtask

    // Samples the output handshake at the edge and moves result_ready just after it
    initial begin
        result_ready = 1'b1;
        stall_state  = SEED;
        forever begin
            @(posedge clock);
            if (!reset && result_valid && result_ready) begin
                take_result();
            end
            #5;
            stall_state  = xorshift32(stall_state);
            result_ready = stall_state[1:0] != 2'b00;
        end
    end

    initial begin
        reset         = 1'b1;
        squash        = 1'b0;
        request_valid = 1'b0;
        request       = '0;
        retire        = '0;
        arn_state     = xorshift32(SEED);
        spec_head     = 0;
        commit_head   = 0;
        for (int i = 0; i < `ARCH_REG_COUNT; i++) begin
            spec_map[i]   = rename_pkg::prn_t'(i);
            commit_map[i] = rename_pkg::prn_t'(i);
        end
        for (int i = `ARCH_REG_COUNT; i < `PHYS_REG_COUNT; i++) begin
            free_order.push_back(rename_pkg::prn_t'(i));
        end

        // Identity sources, then 32 and 33 in slot order
        add_rename(make_request(1, 2, 3, 4, 5, 6), make_result(1, 2, 32, 4, 5, 33));
        // Slot 1 reads slot 0's new register and a zero destination pops nothing
        add_rename(make_request(3, 6, 7, 7, 0, 0), make_result(32, 33, 34, 34, 0, 0));
        add_rename(make_request(7, 3, 0, 8, 6, 8), make_result(34, 32, 0, 8, 33, 35));
        add_step(OP_RANDOM, 14);
        // All 32 free registers are taken, so this bundle waits for retirement
        add_rename(make_request(3, 8, 3, 3, 1, 6), make_result(32, 35, 3, 3, 1, 6));
        add_step(OP_BLOCKED, 8);
        add_step(OP_RETIRE, 2);
        add_step(OP_RETIRE, 2);
        add_rename(make_request(7, 8, 9, 3, 6, 0), make_result(34, 35, 7, 3, 6, 0));
        // After squash the committed map is back and allocation restarts at entry 4
        add_step(OP_SQUASH, 0);
        add_rename(make_request(3, 9, 11, 16, 11, 12), make_result(32, 9, 36, 16, 36, 37));
        add_step(OP_RETIRE, 2);
        add_step(OP_RANDOM, 6);

        repeat (10) @(posedge clock);
        #5;
        reset = 1'b0;
        @(posedge clock);
        check_value(request_ready, 1'b1, "request_ready after reset");
        check_value(result_valid, 1'b0, "result_valid after reset");
        #5;

        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        wait_pending(0, "the last results");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/rename_unit.sv */
`default_nettype none

`include "rename_defs.svh"

module rename_unit (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        squash,

    input  wire logic                        request_valid,
    output logic                             request_ready,
    input  wire rename_pkg::rename_request_t request,

    output logic                             result_valid,
    input  wire logic                        result_ready,
    output rename_pkg::rename_result_t       result,

    input  wire rename_pkg::retire_bundle_t  retire
);

    logic                        held_valid;
    logic                        held_ready;
    rename_pkg::rename_request_t held_request;

    logic                        renamed_valid;
    logic                        renamed_ready;
    rename_pkg::rename_result_t  renamed;

    logic [`RENAME_WIDTH-1:0]                   pop_request;
    rename_pkg::free_slot_t [`RENAME_WIDTH-1:0] pop;
    logic [`FREE_COUNT_WIDTH-1:0]               available;

    rename_pkg::free_slot_t [`RENAME_WIDTH-1:0] push;
    logic [$clog2(`RENAME_WIDTH+1)-1:0]         retire_count;
    rename_pkg::prn_t [`ARCH_REG_COUNT-1:0]     committed_map;

    pipe_stage #(.payload_t(rename_pkg::rename_request_t)) input_stage_i (
        .clock     (clock),
        .reset     (reset),
        .flush     (squash),
        .in_valid  (request_valid),
        .in_ready  (request_ready),
        .in_data   (request),
        .out_valid (held_valid),
        .out_ready (held_ready),
        .out_data  (held_request)
    );

    rename_table rename_table_i (
        .clock         (clock),
        .reset         (reset),
        .squash        (squash),
        .in_valid      (held_valid),
        .in_ready      (held_ready),
        .request       (held_request),
        .out_valid     (renamed_valid),
        .out_ready     (renamed_ready),
        .result        (renamed),
        .pop_request   (pop_request),
        .pop           (pop),
        .available     (available),
        .committed_map (committed_map)
    );

    pipe_stage #(.payload_t(rename_pkg::rename_result_t)) output_stage_i (
        .clock     (clock),
        .reset     (reset),
        .flush     (squash),
        .in_valid  (renamed_valid),
        .in_ready  (renamed_ready),
        .in_data   (renamed),
        .out_valid (result_valid),
        .out_ready (result_ready),
        .out_data  (result)
    );

    free_list free_list_i (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .pop_request  (pop_request),
        .pop          (pop),
        .available    (available),
        .push         (push),
        .retire_count (retire_count)
    );

    retire_table retire_table_i (
        .clock         (clock),
        .reset         (reset),
        .retire        (retire),
        .push          (push),
        .retire_count  (retire_count),
        .committed_map (committed_map)
    );

endmodule

`default_nettype wire

/* logic/retire_table.sv */
`default_nettype none

`include "rename_defs.svh"

module retire_table (
    input  wire logic                                    clock,
    input  wire logic                                    reset,

    input  wire rename_pkg::retire_bundle_t              retire,

    output rename_pkg::free_slot_t [`RENAME_WIDTH-1:0]   push,
    output logic [$clog2(`RENAME_WIDTH+1)-1:0]           retire_count,

    // Includes the retirements of the current cycle
    output rename_pkg::prn_t [`ARCH_REG_COUNT-1:0]       committed_map
);

    rename_pkg::prn_t [`ARCH_REG_COUNT-1:0] committed_q;

    always_comb begin
        committed_map = committed_q;
        retire_count  = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            // Release the old mapping before this slot replaces it
            push[i].valid = retire[i].valid;
            push[i].prn   = committed_map[retire[i].dest_arn];
            if (retire[i].valid) begin
                committed_map[retire[i].dest_arn] = retire[i].dest_prn;
                retire_count = retire_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_COUNT; i++) begin
                committed_q[i] <= rename_pkg::prn_t'(i);
            end
        end else begin
            committed_q <= committed_map;
        end
    end

    // Register zero is never allocated, so it can never retire
    for (genvar lane = 0; lane < `RENAME_WIDTH; lane++) begin : g_retire_check
        no_zero_retire: assert property (
            @(posedge clock) disable iff (reset)
            retire[lane].valid |-> retire[lane].dest_arn != `ZERO_REG
        );
    end

endmodule

`default_nettype wire

/* logic/rename_table.sv */
`default_nettype none

`include "rename_defs.svh"

module rename_table (
    input  wire logic                                          clock,
    input  wire logic                                          reset,
    input  wire logic                                          squash,

    input  wire logic                                          in_valid,
    output logic                                               in_ready,
    input  wire rename_pkg::rename_request_t                   request,

    output logic                                               out_valid,
    input  wire logic                                          out_ready,
    output rename_pkg::rename_result_t                         result,

    output logic [`RENAME_WIDTH-1:0]                           pop_request,
    input  wire rename_pkg::free_slot_t [`RENAME_WIDTH-1:0]    pop,
    input  wire logic [`FREE_COUNT_WIDTH-1:0]                  available,

    input  wire rename_pkg::prn_t [`ARCH_REG_COUNT-1:0]        committed_map
);

    rename_pkg::prn_t [`ARCH_REG_COUNT-1:0] map_q;
    rename_pkg::prn_t [`ARCH_REG_COUNT-1:0] map_next;

    logic [`RENAME_WIDTH-1:0]     dest_live;
    logic [`FREE_COUNT_WIDTH-1:0] needed;
    logic                         enough;
    logic                         accept;

    // Count the destinations that need a fresh register
    always_comb begin
        needed = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            dest_live[i] = request[i].dest_arn != `ZERO_REG;
            if (dest_live[i]) begin
                needed = needed + 1'b1;
            end
        end
    end

    assign enough = available >= needed;

    // A bundle only moves as a whole, so both sides see the same transfer
    assign in_ready  = out_ready && enough && !squash;
    assign out_valid = in_valid && enough && !squash;
    assign accept    = in_valid && in_ready;

    assign pop_request = accept ? dest_live : '0;

    // Later slots see the mappings written by earlier slots of the bundle
    always_comb begin
        map_next = map_q;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            result[i].op1_prn  = map_next[request[i].op1_arn];
            result[i].op2_prn  = map_next[request[i].op2_arn];
            result[i].dest_prn = '0;
            if (dest_live[i]) begin
                result[i].dest_prn = pop[i].prn;
                map_next[request[i].dest_arn] = pop[i].prn;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REG_COUNT; i++) begin
                map_q[i] <= rename_pkg::prn_t'(i);
            end
        end else if (squash) begin
            map_q <= committed_map;
        end else if (accept) begin
            map_q <= map_next;
        end
    end

endmodule

`default_nettype wire

/* logic/free_list.sv */
`default_nettype none

`include "rename_defs.svh"

module free_list (
    input  wire logic                                         clock,
    input  wire logic                                         reset,
    input  wire logic                                         squash,

    input  wire logic [`RENAME_WIDTH-1:0]                     pop_request,
    output rename_pkg::free_slot_t [`RENAME_WIDTH-1:0]        pop,
    output logic [`FREE_COUNT_WIDTH-1:0]                      available,

    input  wire rename_pkg::free_slot_t [`RENAME_WIDTH-1:0]   push,
    input  wire logic [$clog2(`RENAME_WIDTH+1)-1:0]           retire_count
);

    localparam int FREE_MAX = `PHYS_REG_COUNT - `ARCH_REG_COUNT;

    rename_pkg::prn_t entries_q [`PHYS_REG_COUNT];

    logic [`PRN_WIDTH-1:0]        head_q, committed_head_q, tail_q;
    logic [`FREE_COUNT_WIDTH-1:0] count_q;

    logic [`PRN_WIDTH-1:0]        head_next, committed_head_next, tail_next;
    logic [`FREE_COUNT_WIDTH-1:0] count_next;
    logic [`PRN_WIDTH-1:0]        push_index [`RENAME_WIDTH];

    assign available = count_q;

    // The k-th requesting lane reads the k-th entry from the head
    always_comb begin
        logic [`PRN_WIDTH-1:0] offset;
        offset = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            pop[i].prn   = entries_q[head_q + offset];
            pop[i].valid = pop_request[i] && (`FREE_COUNT_WIDTH'(offset) < count_q);
            if (pop_request[i]) begin
                offset = offset + 1'b1;
            end
        end
    end

    always_comb begin
        logic [`PRN_WIDTH-1:0] popped;
        logic [`PRN_WIDTH-1:0] pushed;
        logic [`PRN_WIDTH-1:0] spread;
        popped = '0;
        pushed = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            push_index[i] = tail_q + pushed;
            if (push[i].valid) begin
                pushed = pushed + 1'b1;
            end
            if (pop[i].valid) begin
                popped = popped + 1'b1;
            end
        end
        committed_head_next = committed_head_q + retire_count;
        tail_next = tail_q + pushed;
        spread = tail_next - committed_head_next;
        if (squash) begin
            // Everything past the committed head becomes free again
            head_next  = committed_head_next;
            count_next = `FREE_COUNT_WIDTH'(spread);
        end else begin
            head_next  = head_q + popped;
            count_next = count_q - popped + pushed;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PHYS_REG_COUNT; i++) begin
                entries_q[i] <= rename_pkg::prn_t'(i + `ARCH_REG_COUNT);
            end
            head_q           <= '0;
            committed_head_q <= '0;
            tail_q           <= `PRN_WIDTH'(`ARCH_REG_COUNT);
            count_q          <= `FREE_COUNT_WIDTH'(FREE_MAX);
        end else begin
            for (int i = 0; i < `RENAME_WIDTH; i++) begin
                if (push[i].valid) begin
                    entries_q[push_index[i]] <= push[i].prn;
                end
            end
            head_q           <= head_next;
            committed_head_q <= committed_head_next;
            tail_q           <= tail_next;
            count_q          <= count_next;
        end
    end

    count_bounded: assert property (
        @(posedge clock) disable iff (reset)
        count_q <= `FREE_COUNT_WIDTH'(FREE_MAX)
    );

    for (genvar lane = 0; lane < `RENAME_WIDTH; lane++) begin : g_pop_check
        pop_has_entry: assert property (
            @(posedge clock) disable iff (reset)
            pop_request[lane] |-> pop[lane].valid
        );
    end

endmodule

`default_nettype wire

/* logic/pipe_stage.sv */
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     flush,

    input  wire logic     in_valid,
    output logic          in_ready,
    input  wire payload_t in_data,

    output logic          out_valid,
    input  wire logic     out_ready,
    output payload_t      out_data
);

    logic     valid_q;
    payload_t data_q;

    // Takes a new entry when empty or when the held one leaves this cycle
    assign in_ready  = (!valid_q || out_ready) && !flush;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    held_payload_stable: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready && !flush |=> $stable(out_data)
    );

endmodule

`default_nettype wire

/* logic/rename_pkg.sv */
`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`ARN_WIDTH-1:0] arn_t;
    typedef logic [`PRN_WIDTH-1:0] prn_t;

    // One instruction as it arrives from decode
    typedef struct packed {
        arn_t op1_arn;
        arn_t op2_arn;
        arn_t dest_arn;
    } rename_slot_t;

    typedef rename_slot_t [`RENAME_WIDTH-1:0] rename_request_t;

    // The same instruction after renaming
    typedef struct packed {
        prn_t op1_prn;
        prn_t op2_prn;
        prn_t dest_prn;
    } renamed_slot_t;

    typedef renamed_slot_t [`RENAME_WIDTH-1:0] rename_result_t;

    typedef struct packed {
        logic valid;
        arn_t dest_arn;
        prn_t dest_prn;
    } retire_slot_t;

    typedef retire_slot_t [`RENAME_WIDTH-1:0] retire_bundle_t;

    // A pop or push lane of the free list
    typedef struct packed {
        logic valid;
        prn_t prn;
    } free_slot_t;

endpackage

`default_nettype wire

/* include/rename_defs.svh */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Instructions renamed together in one bundle
`define RENAME_WIDTH 2

`define ARCH_REG_COUNT 32
`define PHYS_REG_COUNT 64

`define ARN_WIDTH 5
`define PRN_WIDTH 6

// Wide enough to hold a count of PHYS_REG_COUNT
`define FREE_COUNT_WIDTH 7

// Reads as physical register 0 and is never given a new mapping
`define ZERO_REG 0

`endif
